/* project.f */
+incdir+.
ieuPkg.sv
extend.sv
regfile.sv
alu.sv
controller.sv
hazard.sv
datapath.sv
ieuCore.sv
ieuChecker.sv
tbIeuCore.sv

/* tbIeuCore.sv */
`include "ieu_macros.svh"

// Testbench top for ieuCore
module tbIeuCore;

  logic          clk;
  logic          rstN;
  logic          instrValid;
  ieuPkg::instrT instr;
  ieuPkg::wbT    wb;
  int            errCount, pending;
  int            testsRun, testsFailed;
  logic [31:0]   lfsr;  // Random source

  ieuCore dut_i (.clk, .rstN, .instrValid, .instr, .wb);

  ieuChecker chk_i (.clk, .rstN, .instrValid, .instr, .wb, .errCount, .pending);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Period 4
  end

  ////////////////////
  // Helpers
  ////////////////////

  // One bit per step, taps 32 22 2 1
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic ieuPkg::instrT rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG};
  endfunction

  function automatic ieuPkg::instrT iType(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, `OP_IMM};
  endfunction

  function automatic ieuPkg::instrT uType(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, `OP_LUI};
  endfunction

  task automatic issue(input ieuPkg::instrT i);  // Strobe for one cycle
    @(negedge clk);
    instrValid = 1'b1;
    instr      = i;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instrValid = 1'b0;
      instr      = '0;
    end
  endtask

  // Drain the pipeline, then report the test
  task automatic endTest(input string name, input int errBefore);
    int t;
    t = 0;
    idle(1);
    while (pending != 0 && t < 50) begin
      @(negedge clk);
      t++;
    end
    testsRun++;
    if (pending != 0) begin
      $display("Timeout: writebacks still outstanding after test %s", name);
      testsFailed++;
    end else begin
      idle(4);  // Room for stray pulses
      if (errCount != errBefore) begin
        testsFailed++;
        $display("Test %s failed with %0d errors", name, errCount - errBefore);
      end else begin
        $display("Test %s passed", name);
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0] v;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          e0;
    lfsr        = 32'h723a;
    testsRun    = 0;
    testsFailed = 0;
    instrValid  = 1'b0;
    instr       = '0;
    rstN        = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    e0 = errCount;  // Quiet pipeline, zero reads
    idle(20);
    issue(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    issue(rType(7'h00, 5'd0, 5'd31, 3'd6, 5'd4));
    endTest("reset", e0);

    e0 = errCount;  // Directed operands
    issue(uType(20'hFFFFF, 5'd1));
    issue(iType(12'h123, 5'd1, 3'd0, 5'd1));  // x1 negative
    issue(iType(12'd7, 5'd0, 3'd0, 5'd2));
    issue(iType(12'hFFF, 5'd0, 3'd0, 5'd3));  // x3 = -1
    for (int k = 0; k < 8; k++) begin
      issue(rType(7'h00, 5'd2, 5'd1, k[2:0], 5'd10 + k[4:0]));
      issue(rType(7'h00, 5'd3, 5'd1, k[2:0], 5'd18 + k[4:0]));
      f3 = k[2:0];
      issue(iType((f3 == 3'd1 || f3 == 3'd5) ? 12'd7 : 12'hED4, 5'd1, f3, 5'd26));
    end
    issue(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd27));  // sub
    issue(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd28));  // sra
    issue(iType({7'h20, 5'd9}, 5'd1, 3'd5, 5'd29));  // srai
    endTest("directed", e0);

    e0 = errCount;  // Forwarding paths
    issue(iType(12'd1, 5'd0, 3'd0, 5'd5));
    repeat (4) issue(rType(7'h00, 5'd5, 5'd5, 3'd0, 5'd5));  // From Memory
    issue(iType(12'd3, 5'd0, 3'd0, 5'd6));
    issue(iType(12'd9, 5'd0, 3'd0, 5'd7));
    issue(rType(7'h00, 5'd7, 5'd6, 3'd0, 5'd8));  // x6 Writeback, x7 Memory
    issue(iType(12'd11, 5'd0, 3'd0, 5'd9));
    idle(2);
    issue(rType(7'h00, 5'd9, 5'd9, 3'd0, 5'd10));  // Register file write-through
    endTest("forwarding", e0);

    e0 = errCount;  // x0 and illegal encodings
    issue(iType(12'd5, 5'd0, 3'd0, 5'd0));
    issue(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    issue(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd11));
    issue({12'd4, 5'd1, 3'd2, 5'd12, 7'b0000011});  // Load, not supported
    issue(rType(7'h20, 5'd2, 5'd1, 3'd1, 5'd12));
    issue(iType({7'h20, 5'd3}, 5'd1, 3'd1, 5'd12));
    issue(rType(7'h00, 5'd0, 5'd12, 3'd0, 5'd13));  // x12 must be unchanged
    endTest("x0 and illegal", e0);

    e0 = errCount;  // Random stream with gaps
    for (int n = 0; n < 320; n++) begin
      v = drawBits(2);
      if (v[1:0] == 2'd3) begin
        v = drawBits(20);
        issue(uType(v[19:0], v[4:0] ^ v[19:15]));
      end else begin
        v  = drawBits(3);
        f3 = v[2:0];
        v  = drawBits(1);
        f7 = (v[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        v  = drawBits(27);
        if (v[26]) begin
          // addi ignores f7, shifts take it from the upper immediate bits
          issue(iType((f3 == 3'd1 || f3 == 3'd5) ? {f7, v[4:0]} : v[11:0],
                      v[16:12], f3, v[21:17]));
        end else begin
          issue(rType(f7, v[11:7], v[16:12], f3, v[21:17]));
        end
      end
      v = drawBits(2);
      idle(v[1:0] == 2'd3 ? 1 : 0);
    end
    endTest("random", e0);

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0 && testsFailed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* ieuChecker.sv */
`include "ieu_macros.svh"

// Scoreboard for the integer pipeline, samples on the rising edge
module ieuChecker (
  input  logic          clk,
  input  logic          rstN,
  input  logic          instrValid,
  input  ieuPkg::instrT instr,
  input  ieuPkg::wbT    wb,
  output int            errCount,  // All failures so far
  output int            pending    // Writebacks still owed
);

  ieuPkg::xlenT shadow [`NREGS];  // Architectural state, in program order
  ieuPkg::wbT   expQ[$];          // Expected pulses, oldest first
  int           dueQ[$];          // Cycle each pulse must appear in
  int           cycle;

  // Sequential RV32I semantics for one instruction, valid low means no write
  function automatic ieuPkg::wbT refModel(ieuPkg::instrT i);
    logic [6:0]   op;
    logic [2:0]   f3;
    logic [6:0]   f7;
    ieuPkg::xlenT a, b, r;
    logic         ok, alt;
    ieuPkg::wbT   e;
    op  = i[6:0];
    f3  = i[14:12];
    f7  = i[31:25];
    a   = shadow[i[19:15]];
    b   = '0;
    r   = '0;
    ok  = 1'b0;
    alt = 1'b0;
    if (op == `OP_REG) begin
      b   = shadow[i[24:20]];
      ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      alt = f7[5];
    end else if (op == `OP_IMM) begin
      b   = {{20{i[31]}}, i[31:20]};  // I immediate
      ok  = (f3 == 3'd1) ? (f7 == 7'h00) :
            (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      alt = (f3 == 3'd5) && f7[5];    // Only srai, never "subi"
    end else if (op == `OP_LUI) begin
      ok = 1'b1;
      r  = {i[31:12], 12'b0};
    end
    if (ok && op != `OP_LUI) begin
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          // Arithmetic form copies the sign bit down
          if (alt) begin
            r = $signed(a) >>> b[4:0];
          end else begin
            r = a >> b[4:0];
          end
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    e.valid  = ok && (i[11:7] != 5'd0);
    e.rd     = i[11:7];
    e.result = e.valid ? r : '0;
    return e;
  endfunction

  initial begin
    errCount = 0;
    pending  = 0;
    cycle    = 0;
    for (int k = 0; k < `NREGS; k++) begin
      shadow[k] = '0;  // Reset state
    end
  end

  ////////////////////
  // Compare process
  ////////////////////

  always @(posedge clk) begin
    ieuPkg::wbT e;
    ieuPkg::wbT h;
    int         d;
    if (rstN) begin
      cycle++;
      if (wb.valid) begin
        if (expQ.size() == 0) begin
          $display("Unexpected writeback pulse at time %0t to x%0d", $time, wb.rd);
          errCount++;
        end else begin
          h = expQ.pop_front();
          d = dueQ.pop_front();
          if (wb !== h) begin
            $display("mismatch at time %0t: x%0d=%h, expected x%0d=%h",
                     $time, wb.rd, wb.result, h.rd, h.result);
            errCount++;
          end else if (d != cycle) begin
            $display("mismatch at time %0t: pulse in cycle %0d, expected cycle %0d",
                     $time, cycle, d);
            errCount++;
          end
        end
      end
      // Head is overdue, the pulse never came
      if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
        h = expQ.pop_front();
        d = dueQ.pop_front();
        $display("Missing writeback to x%0d, due in cycle %0d, at time %0t", h.rd, d, $time);
        errCount++;
      end
      if (instrValid) begin
        e = refModel(instr);
        if (e.valid) begin
          expQ.push_back(e);
          dueQ.push_back(cycle + 3);  // Three clocks after the strobe
          shadow[e.rd] = e.result;
        end
      end
      pending = expQ.size();
    end
  end

endmodule

/* ieuCore.sv */
// Integer execution unit top level
module ieuCore (
  input  logic          clk,
  input  logic          rstN,
  input  logic          instrValid,  // One-cycle strobe, no back-pressure
  input  ieuPkg::instrT instr,
  output ieuPkg::wbT    wb           // Pulses three cycles after the strobe
);

  ieuPkg::ctrlET  ctrlE;
  logic           regWriteM, regWriteW;
  ieuPkg::fwdSelT forwardAE, forwardBE;
  ieuPkg::regAdrT rs1E, rs2E;  // Execute sources
  ieuPkg::regAdrT rdM, rdW;    // Later destinations
  ieuPkg::xlenT   resultW;

  controller ctrl_i (
    .clk, .rstN,
    .instrValid, .instr,
    .ctrlE, .regWriteM, .regWriteW
  );

  hazard haz_i (
    .rs1E, .rs2E, .rdM, .rdW,
    .regWriteM, .regWriteW,
    .forwardAE, .forwardBE
  );

  datapath dp_i (
    .clk, .rstN,
    .instr, .ctrlE, .regWriteW,
    .forwardAE, .forwardBE,
    .rs1E, .rs2E, .rdM, .rdW,
    .resultW
  );

  // Report the register write as it happens
  assign wb = '{valid: regWriteW, rd: rdW, result: resultW};

endmodule

/* datapath.sv */
// Integer datapath, Decode through Writeback
module datapath (
  input  logic           clk,
  input  logic           rstN,
  input  ieuPkg::instrT  instr,      // Instruction in Decode
  input  ieuPkg::ctrlET  ctrlE,      // Controls in Execute
  input  logic           regWriteW,  // Register file write enable
  input  ieuPkg::fwdSelT forwardAE,
  input  ieuPkg::fwdSelT forwardBE,
  output ieuPkg::regAdrT rs1E,
  output ieuPkg::regAdrT rs2E,
  output ieuPkg::regAdrT rdM,
  output ieuPkg::regAdrT rdW,
  output ieuPkg::xlenT   resultW
);

  // Decode stage
  ieuPkg::regAdrT rs1D, rs2D, rdD;
  ieuPkg::xlenT   rd1D, rd2D;    // Register file reads
  ieuPkg::xlenT   immExtD;
  // Execute stage
  ieuPkg::regAdrT rdE;
  ieuPkg::xlenT   rd1E, rd2E, immExtE;
  ieuPkg::xlenT   srcAE;         // Forwarded operand A
  ieuPkg::xlenT   fwdBE;         // Forwarded operand B, before the immediate mux
  ieuPkg::xlenT   srcBE;
  ieuPkg::xlenT   aluResultE;
  ieuPkg::xlenT   resultE;
  // Memory stage
  ieuPkg::xlenT   resultM;

  // Operand select shared by both ALU inputs
  function automatic ieuPkg::xlenT fwdMux(ieuPkg::fwdSelT sel, ieuPkg::xlenT rfVal,
                                          ieuPkg::xlenT wbVal, ieuPkg::xlenT memVal);
    case (sel)
      ieuPkg::fwdMem: return memVal;
      ieuPkg::fwdWb:  return wbVal;
      default:        return rfVal;
    endcase
  endfunction

  ////////////////////
  // Decode
  ////////////////////

  assign rs1D = instr[19:15];
  assign rs2D = instr[24:20];
  assign rdD  = instr[11:7];

  // Written from Writeback, read through in the same cycle
  regfile rf_i (
    .clk, .rstN,
    .we  (regWriteW),
    .rs1 (rs1D),
    .rs2 (rs2D),
    .rd  (rdW),
    .wd  (resultW),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  extend ext_i (.instr, .immExt(immExtD));

  ////////////////////
  // Pipeline registers
  ////////////////////

  // Register numbers reset so forwarding compares start clean
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rs1E <= '0;
      rs2E <= '0;
      rdE  <= '0;
      rdM  <= '0;
      rdW  <= '0;
    end else begin
      rs1E <= rs1D;
      rs2E <= rs2D;
      rdE  <= rdD;
      rdM  <= rdE;
      rdW  <= rdM;
    end
  end

  // Data words, only meaningful alongside a set regWrite
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    immExtE <= immExtD;
    resultM <= resultE;   // Execute to Memory
    resultW <= resultM;   // Memory to Writeback
  end

  ////////////////////
  // Execute
  ////////////////////

  assign srcAE = fwdMux(forwardAE, rd1E, resultW, resultM);
  assign fwdBE = fwdMux(forwardBE, rd2E, resultW, resultM);
  assign srcBE = ctrlE.srcBImm ? immExtE : fwdBE;  // I-type uses the immediate

  alu alu_i (
    .srcA     (srcAE),
    .srcB     (srcBE),
    .aluSel   (ctrlE.aluSel),
    .subArith (ctrlE.subArith),
    .result   (aluResultE)
  );

  assign resultE = ctrlE.luiSel ? immExtE : aluResultE;  // lui skips the ALU

endmodule

/* hazard.sv */
// Forwarding unit, no stalls since every op finishes in Execute
module hazard (
  input  ieuPkg::regAdrT rs1E,
  input  ieuPkg::regAdrT rs2E,
  input  ieuPkg::regAdrT rdM,
  input  ieuPkg::regAdrT rdW,
  input  logic           regWriteM,
  input  logic           regWriteW,
  output ieuPkg::fwdSelT forwardAE,
  output ieuPkg::fwdSelT forwardBE
);

  // Newest producer wins, so Memory is checked first
  function automatic ieuPkg::fwdSelT pickSrc(ieuPkg::regAdrT rs, ieuPkg::regAdrT rdMem,
                                             ieuPkg::regAdrT rdWb, logic wrMem, logic wrWb);
    if (wrMem && rdMem != '0 && rdMem == rs) begin
      return ieuPkg::fwdMem;
    end else if (wrWb && rdWb != '0 && rdWb == rs) begin
      return ieuPkg::fwdWb;
    end
    return ieuPkg::fwdRf;  // Register file value is current
  endfunction

  assign forwardAE = pickSrc(rs1E, rdM, rdW, regWriteM, regWriteW);
  assign forwardBE = pickSrc(rs2E, rdM, rdW, regWriteM, regWriteW);

endmodule

/* controller.sv */
`include "ieu_macros.svh"

// Main decoder plus the control side of the pipeline
module controller (
  input  logic          clk,
  input  logic          rstN,
  input  logic          instrValid,  // Strobe, one cycle per instruction
  input  ieuPkg::instrT instr,       // Instruction in Decode
  output ieuPkg::ctrlET ctrlE,       // Controls in Execute
  output logic          regWriteM,
  output logic          regWriteW
);

  ////////////////////
  // Decode
  ////////////////////

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  logic [6:0]     funct7;
  ieuPkg::regAdrT rdD;
  logic           legalD;  // Encoding is one we execute
  ieuPkg::ctrlET  ctrlD;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rdD    = instr[11:7];

  always_comb begin
    ctrlD        = '0;      // spare stays low
    legalD       = 1'b0;
    ctrlD.aluSel = funct3;  // ALU op is funct3 directly
    case (opcode)
      `OP_REG: begin
        // Only funct7 0x20 with add or sra is a second encoding
        legalD = (funct7 == 7'b0000000) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        ctrlD.subArith = funct7[5];
      end
      `OP_IMM: begin
        ctrlD.srcBImm = 1'b1;
        case (funct3)
          3'b001:  legalD = (funct7 == 7'b0000000);  // slli
          3'b101:  legalD = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: legalD = 1'b1;  // Plain 12-bit immediate
        endcase
        // addi has no subtract form
        ctrlD.subArith = (funct3 == 3'b101) && funct7[5];
      end
      `OP_LUI: begin
        legalD       = 1'b1;
        ctrlD.luiSel = 1'b1;  // ALU result ignored
      end
      default: legalD = 1'b0;  // Illegal, dropped quietly
    endcase
    // No write for gaps, illegal ops or rd = x0
    ctrlD.regWrite = instrValid && legalD && (rdD != '0);
  end

  ////////////////////
  // Pipeline
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctrlE     <= '0;
      regWriteM <= 1'b0;
      regWriteW <= 1'b0;
    end else begin
      ctrlE     <= ctrlD;           // Decode to Execute
      regWriteM <= ctrlE.regWrite;  // Execute to Memory
      regWriteW <= regWriteM;       // Memory to Writeback
    end
  end

endmodule

/* alu.sv */
// Integer ALU for the RV32I register and immediate ops
module alu (
  input  ieuPkg::xlenT   srcA,
  input  ieuPkg::xlenT   srcB,
  input  ieuPkg::aluSelT aluSel,    // funct3 of the instruction
  input  logic           subArith,  // sub / sra
  output ieuPkg::xlenT   result
);

  ieuPkg::xlenT sum;      // Adder output
  logic [4:0]   shamt;    // Shift amount, low bits only
  logic         ltSgn;    // Signed less than
  logic         ltUns;    // Unsigned less than

  assign sum   = subArith ? srcA - srcB : srcA + srcB;
  assign shamt = srcB[4:0];
  assign ltSgn = $signed(srcA) < $signed(srcB);
  assign ltUns = srcA < srcB;

  always_comb begin
    case (aluSel)
      3'b000: result = sum;                    // add, sub, addi
      3'b001: result = srcA << shamt;          // sll
      3'b010: result = ieuPkg::xlenT'(ltSgn);  // slt
      3'b011: result = ieuPkg::xlenT'(ltUns);  // sltu
      3'b100: result = srcA ^ srcB;            // xor
      3'b101: begin
        // Right shifts, arithmetic keeps the sign bit
        if (subArith) begin
          result = ieuPkg::xlenT'($signed(srcA) >>> shamt);
        end else begin
          result = srcA >> shamt;
        end
      end
      3'b110: result = srcA | srcB;            // or
      default: result = srcA & srcB;           // and
    endcase
  end

endmodule

/* regfile.sv */
`include "ieu_macros.svh"

// Integer register file, 2 read ports and 1 write port
module regfile (
  input  logic           clk,
  input  logic           rstN,
  input  logic           we,   // Write enable from Writeback
  input  ieuPkg::regAdrT rs1,
  input  ieuPkg::regAdrT rs2,
  input  ieuPkg::regAdrT rd,
  input  ieuPkg::xlenT   wd,
  output ieuPkg::xlenT   rd1,
  output ieuPkg::xlenT   rd2
);

  ieuPkg::xlenT regs [`NREGS];  // Storage, entry 0 never written

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // x0 writes dropped
      regs[rd] <= wd;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rd1 = (rs1 == '0)             ? '0 :
               (we && rd == rs1)       ? wd : regs[rs1];
  assign rd2 = (rs2 == '0)             ? '0 :
               (we && rd == rs2)       ? wd : regs[rs2];

endmodule

/* extend.sv */
`include "ieu_macros.svh"

// Immediate generation for the kept formats
module extend (
  input  ieuPkg::instrT instr,
  output ieuPkg::xlenT  immExt
);

  logic [6:0]   opcode;  // Local copy of the major opcode
  ieuPkg::xlenT immI;    // I-type, sign extended
  ieuPkg::xlenT immU;    // U-type, low bits zero

  assign opcode = instr[6:0];

  // Bit 31 is the sign for both formats
  assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign immU = {instr[31:12], 12'b0};

  // lui takes the upper form, ALU immediates take the I form
  always_comb begin
    if (opcode == `OP_LUI) begin
      immExt = immU;
    end else begin
      immExt = immI;  // Also harmless for register ops
    end
  end

endmodule

/* ieuPkg.sv */
`include "ieu_macros.svh"

package ieuPkg;

  ////////////////////
  // Plain vector types
  ////////////////////

  typedef logic [`XLEN-1:0]           xlenT;    // One data word
  typedef logic [$clog2(`NREGS)-1:0]  regAdrT;  // Register number
  typedef logic [31:0]                instrT;   // Raw RV32I instruction
  typedef logic [2:0]                 aluSelT;  // ALU op, straight from funct3
  typedef logic [1:0]                 fwdSelT;  // Operand source in Execute

  // Forwarding mux codes
  localparam fwdSelT fwdRf  = 2'b00;  // Value read in Decode
  localparam fwdSelT fwdWb  = 2'b01;  // Result sitting in Writeback
  localparam fwdSelT fwdMem = 2'b10;  // Result sitting in Memory

  ////////////////////
  // Execute controls
  ////////////////////

  // Built in Decode, registered into Execute
  typedef struct packed {
    aluSelT aluSel;    // Operation group
    logic   subArith;  // Subtract or arithmetic right shift
    logic   srcBImm;   // Source B is the immediate
    logic   luiSel;    // Result is the U immediate itself
    logic   regWrite;  // Instruction writes rd
    logic   spare;     // Held at zero
  } ctrlET;

  ////////////////////
  // Writeback report
  ////////////////////

  // One pulse per register write, seen at the top level
  typedef struct packed {
    logic   valid;
    regAdrT rd;
    xlenT   result;
  } wbT;

endpackage

/* ieu_macros.svh */
`ifndef IEU_MACROS_SVH
`define IEU_MACROS_SVH

////////////////////
// Widths
////////////////////

`define XLEN  32           // Integer data width
`define NREGS 32           // Architectural integer registers

////////////////////
// RV32I major opcodes
////////////////////

`define OP_REG 7'b0110011  // Register-register ALU ops
`define OP_IMM 7'b0010011  // Register-immediate ALU ops
`define OP_LUI 7'b0110111  // Load upper immediate

// Anything else is treated as illegal and never writes a register

`endif
